// ==== verilog/div_pkg.sv ====
// Shared widths, step counts and request type of the iterative divider
// Every RTL file refers to these by scoped name

`default_nettype none

package div_pkg;

   localparam int XLEN    = 32;  // Operand and result width
   localparam int CNT_W   = 6;   // Step counter width
   localparam int SMALL_W = 4;   // Fast path operand and quotient width

   // Step counts sized to the counter
   localparam logic [CNT_W-1:0] QUOT_STEPS = CNT_W'(32);
   localparam logic [CNT_W-1:0] REM_STEPS  = CNT_W'(33);  // Plus remainder correction

   typedef logic [XLEN-1:0] xlen_t;

   // One divide request
   typedef struct packed {
      logic is_unsigned;  // DIVU or REMU
      logic want_rem;     // Return the remainder
   } div_op_t;

endpackage

`default_nettype wire

// ==== verilog/div_operand_if.sv ====
// Registered operand magnitudes and sign flags of the request in flight
// Driven by operand prep and read by the lookup, sequencer, core and fixup

`default_nettype none

interface div_operand_if;

   logic             load;          // Operands newly registered
   div_pkg::xlen_t   dividend_mag;
   div_pkg::xlen_t   divisor_mag;
   div_pkg::div_op_t op;
   logic             neg_quot;      // Quotient needs negation
   logic             neg_rem;       // Remainder needs negation

   modport prep (
      output load,
      output dividend_mag,
      output divisor_mag,
      output op,
      output neg_quot,
      output neg_rem
   );

   modport sink (
      input load,
      input dividend_mag,
      input divisor_mag,
      input op,
      input neg_quot,
      input neg_rem
   );

endinterface

`default_nettype wire

// ==== verilog/div_step_if.sv ====
// Step commands from the sequencer to the non-restoring core
// The core returns the sign of its partial remainder

`default_nettype none

interface div_step_if;

   logic iterate;  // One shift and add/subtract step
   logic correct;  // Add the divisor back to the remainder
   logic clear;    // Abort and clear
   logic pr_neg;   // Partial remainder is negative

   modport seq (
      output iterate,
      output correct,
      output clear,
      input  pr_neg
   );

   modport core (
      input  iterate,
      input  correct,
      input  clear,
      output pr_neg
   );

endinterface

`default_nettype wire

// ==== verilog/div_operand_prep.sv ====
// Operand capture stage of the divider
// Takes a request on start while idle and registers magnitudes and
// result sign flags for the later stages

`default_nettype none

module div_operand_prep (
   input  logic             clk,
   input  logic             arst_n,
   input  logic             start,
   input  logic             busy,
   input  div_pkg::div_op_t op,
   input  div_pkg::xlen_t   dividend,
   input  div_pkg::xlen_t   divisor,
   div_operand_if.prep      opnd
);

   logic           accept;
   logic           dividend_neg;  // Signed request with negative operand
   logic           divisor_neg;
   logic           divisor_zero;
   div_pkg::xlen_t dividend_abs;
   div_pkg::xlen_t divisor_abs;

   assign accept       = start & ~busy;  // Starts during a run are dropped
   assign dividend_neg = ~op.is_unsigned & dividend[div_pkg::XLEN-1];
   assign divisor_neg  = ~op.is_unsigned & divisor[div_pkg::XLEN-1];
   assign divisor_zero = (divisor == '0);

   // Most negative number maps onto itself as an unsigned magnitude
   assign dividend_abs = dividend_neg ? -dividend : dividend;
   assign divisor_abs  = divisor_neg ? -divisor : divisor;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         opnd.load <= 1'b0;
      end else begin
         opnd.load <= accept;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         opnd.dividend_mag <= dividend_abs;
         opnd.divisor_mag  <= divisor_abs;
         opnd.op           <= op;
         // Divide by zero keeps the all ones quotient
         opnd.neg_quot     <= (dividend_neg ^ divisor_neg) & ~divisor_zero;
         opnd.neg_rem      <= dividend_neg;  // Remainder follows the dividend
      end
   end

endmodule

`default_nettype wire

// ==== verilog/div_small_lookup.sv ====
// Small operand fast path
// Flags quotient requests whose magnitudes fit in 4 bits and gives their
// quotient in the load cycle

`default_nettype none

module div_small_lookup (
   div_operand_if.sink                 opnd,
   input  logic                        fast_disable,
   output logic                        small_hit,
   output logic [div_pkg::SMALL_W-1:0] small_quot
);

   logic                        both_small;
   logic [div_pkg::SMALL_W-1:0] num;
   logic [div_pkg::SMALL_W-1:0] den;

   assign num = opnd.dividend_mag[div_pkg::SMALL_W-1:0];
   assign den = opnd.divisor_mag[div_pkg::SMALL_W-1:0];

   // Upper bits of both magnitudes clear
   assign both_small = (opnd.dividend_mag[div_pkg::XLEN-1:div_pkg::SMALL_W] == '0) &
                       (opnd.divisor_mag[div_pkg::XLEN-1:div_pkg::SMALL_W] == '0);

   // Divide by zero always takes the long path
   assign small_hit = opnd.load & ~opnd.op.want_rem & both_small & (den != '0) &
                      ~fast_disable;

   assign small_quot = (den == '0) ? '0 : num / den;

endmodule

`default_nettype wire

// ==== verilog/div_sequencer.sv ====
// Run control of the divider
// Counts the non-restoring steps and issues the correction step
// Signals finish in the last compute cycle and aborts on flush

`default_nettype none

module div_sequencer (
   input  logic        clk,
   input  logic        arst_n,
   div_operand_if.sink opnd,
   input  logic        small_hit,
   input  logic        flush,
   div_step_if.seq     step,
   output logic        busy,
   output logic        finish
);

   logic                      run;   // Iterating after the load cycle
   logic                      tail;  // Cycle in which done pulses
   logic [div_pkg::CNT_W-1:0] count;
   logic [div_pkg::CNT_W-1:0] last_count;

   assign last_count = opnd.op.want_rem ? div_pkg::REM_STEPS : div_pkg::QUOT_STEPS;

   // Step one runs in the load cycle and count holds the steps done
   assign step.iterate = (opnd.load & ~small_hit) | (run & (count < div_pkg::QUOT_STEPS));
   assign step.correct = run & (count == div_pkg::QUOT_STEPS) & opnd.op.want_rem &
                         step.pr_neg;  // Only a negative remainder needs it
   assign step.clear   = flush;

   assign finish = small_hit | (run & (count == last_count));
   assign busy   = opnd.load | run | tail;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         run   <= 1'b0;
         tail  <= 1'b0;
         count <= '0;
      end else begin
         tail <= finish & ~flush;
         if (flush || finish) begin
            run   <= 1'b0;
            count <= '0;
         end else if (opnd.load) begin
            run   <= 1'b1;
            count <= {{(div_pkg::CNT_W-1){1'b0}}, 1'b1};
         end else if (run) begin
            count <= count + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== verilog/div_nonrestoring_core.sv ====
// Non-restoring divide datapath
// Partial remainder and quotient shift left together each step
// The quotient register starts with the dividend magnitude

`default_nettype none

module div_nonrestoring_core (
   input  logic           clk,
   input  logic           arst_n,
   div_operand_if.sink    opnd,
   div_step_if.core       step,
   output div_pkg::xlen_t quot_mag,
   output div_pkg::xlen_t rem_mag
);

   logic [div_pkg::XLEN:0] pr_q;      // Signed partial remainder
   logic [div_pkg::XLEN:0] pr_cur;
   logic [div_pkg::XLEN:0] pr_shift;
   logic [div_pkg::XLEN:0] pr_next;
   logic [div_pkg::XLEN:0] div_ext;   // Divisor with a zero sign bit
   div_pkg::xlen_t         q_q;
   div_pkg::xlen_t         q_cur;

   // In the load cycle the first step starts from the initial values
   assign pr_cur = opnd.load ? '0 : pr_q;
   assign q_cur  = opnd.load ? opnd.dividend_mag : q_q;

   // Divisor magnitude is held by prep until the run ends
   assign div_ext = {1'b0, opnd.divisor_mag};

   assign pr_shift = {pr_cur[div_pkg::XLEN-1:0], q_cur[div_pkg::XLEN-1]};

   // Add after a negative remainder and subtract otherwise
   // The shifted top bit may wrap since the sum is back in range
   assign pr_next = pr_cur[div_pkg::XLEN] ? pr_shift + div_ext : pr_shift - div_ext;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pr_q <= '0;
         q_q  <= '0;
      end else if (step.clear) begin
         pr_q <= '0;
         q_q  <= '0;
      end else if (step.iterate) begin
         pr_q <= pr_next;
         q_q  <= {q_cur[div_pkg::XLEN-2:0], ~pr_next[div_pkg::XLEN]};  // New bit is 1 if not negative
      end else if (step.correct) begin
         pr_q <= pr_q + div_ext;  // Restore final remainder
      end
   end

   assign step.pr_neg = pr_q[div_pkg::XLEN];

   assign quot_mag = q_q;
   assign rem_mag  = pr_q[div_pkg::XLEN-1:0];

endmodule

`default_nettype wire

// ==== verilog/div_result_fixup.sv ====
// Result stage of the divider
// Picks the small quotient, remainder or quotient, applies the sign and
// registers it with the done pulses

`default_nettype none

module div_result_fixup (
   input  logic                        clk,
   input  logic                        arst_n,
   div_operand_if.sink                 opnd,
   input  logic                        finish,
   input  logic                        small_hit,
   input  logic [div_pkg::SMALL_W-1:0] small_quot,
   input  div_pkg::xlen_t              quot_mag,
   input  div_pkg::xlen_t              rem_mag,
   input  logic                        flush,
   output logic                        done,
   output logic                        done_early,
   output div_pkg::xlen_t              result
);

   logic           capture;
   logic           negate;
   div_pkg::xlen_t pick;
   div_pkg::xlen_t signed_res;

   assign capture = finish & ~flush;

   always_comb begin
      if (small_hit) begin
         pick   = {{(div_pkg::XLEN-div_pkg::SMALL_W){1'b0}}, small_quot};
         negate = opnd.neg_quot;
      end else if (opnd.op.want_rem) begin
         pick   = rem_mag;
         negate = opnd.neg_rem;
      end else begin
         pick   = quot_mag;
         negate = opnd.neg_quot;
      end
   end

   assign signed_res = negate ? -pick : pick;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         done       <= 1'b0;
         done_early <= 1'b0;
         result     <= '0;
      end else begin
         done       <= capture;
         done_early <= capture & small_hit;
         if (capture) begin
            result <= signed_res;  // Held until the next done
         end
      end
   end

endmodule

`default_nettype wire

// ==== verilog/div_top.sv ====
// Top level of the 32-bit iterative divider
// Pulse start while busy is low and the result comes with done
// Quotients of small operands finish early unless fast_disable is set

`default_nettype none

module div_top (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic                     start,
   input  logic                     is_unsigned,
   input  logic                     want_rem,
   input  logic [div_pkg::XLEN-1:0] dividend,
   input  logic [div_pkg::XLEN-1:0] divisor,
   input  logic                     flush,
   input  logic                     fast_disable,
   output logic                     busy,
   output logic                     done,
   output logic                     done_early,
   output logic [div_pkg::XLEN-1:0] result
);

   div_pkg::div_op_t            op;
   logic                        small_hit;
   logic [div_pkg::SMALL_W-1:0] small_quot;
   logic                        finish;
   div_pkg::xlen_t              quot_mag;
   div_pkg::xlen_t              rem_mag;

   div_operand_if opnd_bus ();
   div_step_if    step_bus ();

   assign op.is_unsigned = is_unsigned;
   assign op.want_rem    = want_rem;

   div_operand_prep i_operand_prep (
      .clk      (clk),
      .arst_n   (arst_n),
      .start    (start),
      .busy     (busy),
      .op       (op),
      .dividend (dividend),
      .divisor  (divisor),
      .opnd     (opnd_bus.prep)
   );

   div_small_lookup i_small_lookup (
      .opnd         (opnd_bus.sink),
      .fast_disable (fast_disable),
      .small_hit    (small_hit),
      .small_quot   (small_quot)
   );

   div_sequencer i_sequencer (
      .clk       (clk),
      .arst_n    (arst_n),
      .opnd      (opnd_bus.sink),
      .small_hit (small_hit),
      .flush     (flush),
      .step      (step_bus.seq),
      .busy      (busy),
      .finish    (finish)
   );

   div_nonrestoring_core i_core (
      .clk      (clk),
      .arst_n   (arst_n),
      .opnd     (opnd_bus.sink),
      .step     (step_bus.core),
      .quot_mag (quot_mag),
      .rem_mag  (rem_mag)
   );

   div_result_fixup i_result_fixup (
      .clk        (clk),
      .arst_n     (arst_n),
      .opnd       (opnd_bus.sink),
      .finish     (finish),
      .small_hit  (small_hit),
      .small_quot (small_quot),
      .quot_mag   (quot_mag),
      .rem_mag    (rem_mag),
      .flush      (flush),
      .done       (done),
      .done_early (done_early),
      .result     (result)
   );

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
// Clock and reset source for the divider testbench
// 4 ns clock, reset held low for the first 5 cycles

`default_nettype none

module tb_clock_gen (
   output logic clk,
   output logic arst_n
);

   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk    = 1'b0;
      arst_n = 1'b0;
   end

   always #2 clk = ~clk;

   initial begin
      repeat (5) @(posedge clk);
      arst_n <= 1'b1;  // Release on an edge
   end

endmodule

`default_nettype wire

// ==== testbench/tb_div_top.sv ====
// Testbench of the iterative divider
// Runs random, corner, fast path, flush and busy start cases against a
// reference model and checks result and done timing

`default_nettype none

module tb_div_top;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int CYCLE_LIMIT = 20000;  // About 400 ops of up to 38 cycles
   localparam int RAND_OPS    = 320;

   logic        clk;
   logic        arst_n;
   logic        start;
   logic        is_unsigned;
   logic        want_rem;
   logic [31:0] dividend;
   logic [31:0] divisor;
   logic        flush;
   logic        fast_disable;
   logic        busy;
   logic        done;
   logic        done_early;
   logic [31:0] result;

   int          cyc;
   logic [31:0] lcg_state;

   // Outstanding requests, oldest first
   logic [31:0] exp_res[$];
   int          exp_lat[$];
   logic        exp_early[$];
   int          exp_t[$];

   tb_clock_gen i_clock_gen (
      .clk    (clk),
      .arst_n (arst_n)
   );

   div_top i_div_top (
      .clk          (clk),
      .arst_n       (arst_n),
      .start        (start),
      .is_unsigned  (is_unsigned),
      .want_rem     (want_rem),
      .dividend     (dividend),
      .divisor      (divisor),
      .flush        (flush),
      .fast_disable (fast_disable),
      .busy         (busy),
      .done         (done),
      .done_early   (done_early),
      .result       (result)
   );

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   // Full word from the upper halves of two draws
   function automatic logic [31:0] rand_word();
      logic [31:0] hi;
      logic [31:0] lo;
      hi = next_rand();
      lo = next_rand();
      return {hi[31:16], lo[31:16]};
   endfunction

   // RISC-V DIV, DIVU, REM and REMU
   function automatic logic [31:0] ref_div(input logic [31:0] a, input logic [31:0] b,
                                           input logic uns, input logic rem);
      if (b == 32'd0)
         return rem ? a : 32'hffff_ffff;
      if (uns)
         return rem ? a % b : a / b;
      if (a == 32'h8000_0000 && b == 32'hffff_ffff)
         return rem ? 32'd0 : a;  // Signed overflow
      return rem ? $signed(a) % $signed(b) : $signed(a) / $signed(b);
   endfunction

   function automatic logic [31:0] magnitude(input logic [31:0] x, input logic uns);
      return (!uns && x[31]) ? -x : x;
   endfunction

   // Cycles from the start cycle to the done cycle
   function automatic int ref_latency(input logic [31:0] a, input logic [31:0] b,
                                      input logic uns, input logic rem, input logic fd);
      if (!rem && !fd && b != 32'd0 && magnitude(a, uns) < 16 && magnitude(b, uns) < 16)
         return 2;
      return rem ? 35 : 34;
   endfunction

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, actual,
                  expected);
         $display("TEST FAILED");
         $fatal(1);
      end
   endtask

   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (cyc >= CYCLE_LIMIT) begin
         $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("TEST FAILED");
         $fatal(1);
      end
   end

   // Scoreboard samples away from the driving edge
   always @(negedge clk) begin : scoreboard
      logic [31:0] r;
      if (arst_n && done) begin
         if (exp_res.size() == 0) begin
            $display("A done pulse came at %0t with no request outstanding", $time);
            $display("TEST FAILED");
            $fatal(1);
         end else begin
            r = exp_res.pop_front();
            check_value(result, r, "result");
            check_value(cyc - exp_t.pop_front(), exp_lat.pop_front(), "done latency");
            check_value(done_early, exp_early.pop_front(), "done_early");
            check_value(busy, 1, "busy at done");
         end
      end
   end

   task automatic wait_idle();
      @(negedge clk);
      while (busy) @(negedge clk);
   endtask

   // Drives one start cycle and returns its cycle number
   task automatic send(input logic [31:0] a, input logic [31:0] b, input logic uns,
                       input logic rem, input logic fd, output int t);
      @(posedge clk);
      start        <= 1'b1;
      dividend     <= a;
      divisor      <= b;
      is_unsigned  <= uns;
      want_rem     <= rem;
      fast_disable <= fd;
      @(negedge clk);
      t = cyc;
      @(posedge clk);
      start <= 1'b0;
   endtask

   task automatic expect_op(input logic [31:0] a, input logic [31:0] b, input logic uns,
                            input logic rem, input logic fd, input int t);
      int lat;
      lat = ref_latency(a, b, uns, rem, fd);
      exp_res.push_back(ref_div(a, b, uns, rem));
      exp_lat.push_back(lat);
      exp_early.push_back(lat == 2);
      exp_t.push_back(t);
   endtask

   task automatic run_op(input logic [31:0] a, input logic [31:0] b, input logic uns,
                         input logic rem, input logic fd);
      int t;
      wait_idle();
      send(a, b, uns, rem, fd, t);
      expect_op(a, b, uns, rem, fd, t);
      while (exp_res.size() > 0) @(posedge clk);
      @(negedge clk);
      check_value(busy, 0, "busy after done");  // Cycle after done
   endtask

   initial begin : stimulus
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] sel;
      int          t;
      start        = 1'b0;
      is_unsigned  = 1'b0;
      want_rem     = 1'b0;
      dividend     = '0;
      divisor      = '0;
      flush        = 1'b0;
      fast_disable = 1'b0;
      cyc          = 0;
      lcg_state    = 32'd73;

      wait (arst_n === 1'b1);
      @(negedge clk);
      check_value(busy, 0, "busy after reset");
      check_value(done, 0, "done after reset");
      check_value(done_early, 0, "done_early after reset");
      check_value(result, 0, "result after reset");

      for (int i = 0; i < RAND_OPS; i++) begin
         a   = rand_word();
         b   = rand_word();
         sel = next_rand();
         b   = b >> sel[27:23];  // Spread the quotient sizes
         run_op(a, b, sel[31], sel[30], 1'b0);
      end

      // Zero divisor, overflow, exact and zero results
      for (int k = 0; k < 4; k++) begin
         run_op(32'h1234_5678, 32'd0, k[0], k[1], 1'b0);
         run_op(32'hffff_fff3, 32'd0, k[0], k[1], 1'b0);
         run_op(32'h8000_0000, 32'hffff_ffff, k[0], k[1], 1'b0);
         run_op(32'hffff_ff9c, 32'd10, k[0], k[1], 1'b0);       // -100 / 10
         run_op(32'd0, 32'hffff_fffd, k[0], k[1], 1'b0);
         run_op(32'hffff_fff9, 32'hffff_fff9, k[0], k[1], 1'b0);
      end

      // Small operands with the fast path on then off
      for (int i = 0; i < 16; i++) begin
         a   = next_rand() >> 28;
         b   = (next_rand() >> 28) % 15 + 1;
         sel = next_rand();
         if (sel[31])
            a = -a;
         if (sel[30])
            b = -b;
         run_op(a, b, 1'b0, 1'b0, 1'b0);
         run_op(a, b, 1'b0, 1'b0, 1'b1);
      end

      // Flush in the middle of a run
      wait_idle();
      send(32'd1000, 32'd7, 1'b1, 1'b0, 1'b0, t);
      repeat (10) @(posedge clk);
      flush <= 1'b1;
      @(posedge clk);
      flush <= 1'b0;
      @(negedge clk);
      check_value(busy, 0, "busy after flush");
      repeat (40) @(negedge clk);  // Any done here is a stray one
      run_op(32'd1000, 32'd7, 1'b1, 1'b1, 1'b0);

      // Second start while busy is dropped
      wait_idle();
      send(32'hfedc_ba98, 32'd3, 1'b0, 1'b0, 1'b0, t);
      expect_op(32'hfedc_ba98, 32'd3, 1'b0, 1'b0, 1'b0, t);
      repeat (5) @(posedge clk);
      start    <= 1'b1;
      dividend <= 32'd55;
      divisor  <= 32'd5;
      @(posedge clk);
      start <= 1'b0;
      while (exp_res.size() > 0) @(posedge clk);
      repeat (40) @(negedge clk);
      check_value(busy, 0, "busy after dropped start");

      $display("TEST PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== files.f ====
verilog/div_pkg.sv
verilog/div_operand_if.sv
verilog/div_step_if.sv
verilog/div_operand_prep.sv
verilog/div_small_lookup.sv
verilog/div_sequencer.sv
verilog/div_nonrestoring_core.sv
verilog/div_result_fixup.sv
verilog/div_top.sv
testbench/tb_clock_gen.sv
testbench/tb_div_top.sv
